// File: Makefile
# Verilator build and run for the memory/writeback pipeline testbench.

VERILATOR ?= verilator
TOP       ?= memWbTb
FILELIST  ?= memWbTop.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/dataRam.sv
`timescale 1ns/1ns
`include "memWb_cfg.svh"

module dataRam
    import memWbPkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  wbReqT wbReq,
    output wbRspT wbRsp
);

    logic [`DATA_W-1:0] mem [`RAM_WORDS];
    logic               ackQ;
    logic [`DATA_W-1:0] datRQ;
    logic               access;

    // First cycle of a strobe. The ack cycle itself does not count again.
    assign access = wbReq.cyc && wbReq.stb && !ackQ;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            ackQ <= 1'b0;
        else
            ackQ <= access;
    end

    always_ff @(posedge clk)
    begin
        if (access)
        begin
            datRQ <= mem[wbReq.adr];
            if (wbReq.we)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (wbReq.sel[i])
                        mem[wbReq.adr][8*i +: 8] <= wbReq.datW[8*i +: 8];
                end
            end
        end
    end

    assign wbRsp.ack  = ackQ;
    assign wbRsp.datR = datRQ;

    ackInCycle: assert property (
        @(posedge clk) disable iff (!rstN)
        wbRsp.ack |-> wbReq.cyc && wbReq.stb
    ) else $error("dataRam: ack outside a bus cycle");

endmodule

// File: logic/memAccessStage.sv
`timescale 1ns/1ns
`include "memWb_cfg.svh"

module memAccessStage
    import memWbPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   inValid,
    output logic   inReady,
    input  exMemT  req,
    output logic   outValid,
    input  logic   outReady,
    output memWbT  res,
    output wbReqT  wbReq,
    input  wbRspT  wbRsp
);

    typedef enum logic [1:0] {
        stIdle,
        stBus,
        stDone
    } stateT;

    stateT              state;
    stateT              stateNext;
    logic               isMem;
    logic               busy;
    logic [3:0]         sel;
    logic [`DATA_W-1:0] datW;
    logic [`DATA_W-1:0] memWordQ;

    assign isMem = req.memOp.read || req.memOp.write;

    // The request stays in the input register until the result leaves,
    // so the bus fields can be taken straight from it.
    assign busy = (state == stIdle && inValid && isMem) || state == stBus;

    always_comb
    begin
        stateNext = state;
        case (state)
            stIdle: if (inValid && isMem) stateNext = stBus;
            stBus:  if (wbRsp.ack) stateNext = stDone;
            stDone: if (outReady) stateNext = stIdle;
            default: stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            state <= stIdle;
        else
            state <= stateNext;
    end

    always_ff @(posedge clk)
    begin
        if (state == stBus && wbRsp.ack)
            memWordQ <= wbRsp.datR;
    end

    // Big-endian lanes. Address 0 is the top byte.
    always_comb
    begin
        case (req.memOp.size)
            sizeByte:
            begin
                datW = {4{req.storeData[7:0]}};
                sel  = 4'b1000 >> req.aluResult[1:0];
            end
            sizeHalf:
            begin
                datW = {2{req.storeData[15:0]}};
                sel  = req.aluResult[1] ? 4'b0011 : 4'b1100;
            end
            default:
            begin
                datW = req.storeData;
                sel  = 4'b1111;
            end
        endcase
    end

    always_comb
    begin
        wbReq.cyc  = busy;
        wbReq.stb  = busy;
        wbReq.we   = req.memOp.write;
        wbReq.adr  = req.aluResult[wbAdrW+1:2];
        wbReq.sel  = sel;
        wbReq.datW = datW;
    end

    assign outValid = (state == stIdle && inValid && !isMem) || state == stDone;
    assign inReady  = ((state == stIdle && !isMem) || state == stDone) && outReady;

    always_comb
    begin
        res.aluResult = req.aluResult;
        res.dest      = req.dest;
        res.regWrite  = req.regWrite;
        res.excTaken  = req.excTaken;
        res.pc        = req.pc;
        res.hiLoWe    = req.hiLoWe;
        res.hiLoData  = req.hiLoData;
        res.size      = req.memOp.size;
        res.signExt   = req.memOp.signExt;
        res.fromMem   = req.memOp.read;
        res.memWord   = memWordQ;
    end

    excNoMem: assert property (
        @(posedge clk) disable iff (!rstN)
        inValid && req.excTaken |-> !req.memOp.read && !req.memOp.write
    ) else $error("memAccessStage: excepting instruction carries a memory op");

    noReadWrite: assert property (
        @(posedge clk) disable iff (!rstN)
        inValid |-> !(req.memOp.read && req.memOp.write)
    ) else $error("memAccessStage: read and write both set");

    // Request held until the slave acks.
    busHold: assert property (
        @(posedge clk) disable iff (!rstN)
        wbReq.stb && !wbRsp.ack |=> wbReq.stb && $stable(wbReq)
    ) else $error("memAccessStage: bus request changed before ack");

endmodule

// File: logic/memWbPkg.sv
`include "memWb_cfg.svh"

package memWbPkg;

    localparam int wbAdrW = $clog2(`RAM_WORDS); // Word address bits on the bus.

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accSizeT;

    typedef struct packed {
        logic    read;
        logic    write;
        accSizeT size;
        logic    signExt;
    } memOpT;

    // One result handed over from the execute stage.
    typedef struct packed {
        logic [`DATA_W-1:0]   aluResult; // Also the byte address for loads and stores.
        logic [`DATA_W-1:0]   storeData;
        memOpT                memOp;
        logic [`DEST_W-1:0]   dest;
        logic                 regWrite;
        logic                 excTaken;
        logic [`DATA_W-1:0]   pc;
        logic                 hiLoWe;
        logic [2*`DATA_W-1:0] hiLoData;
    } exMemT;

    typedef struct packed {
        logic [`DATA_W-1:0]   aluResult;
        logic [`DEST_W-1:0]   dest;
        logic                 regWrite;
        logic                 excTaken;
        logic [`DATA_W-1:0]   pc;
        logic                 hiLoWe;
        logic [2*`DATA_W-1:0] hiLoData;
        accSizeT              size;
        logic                 signExt;
        logic                 fromMem;
        logic [`DATA_W-1:0]   memWord; // Raw word as read from RAM.
    } memWbT;

    typedef struct packed {
        logic               we;
        logic [`DEST_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } rfWriteT;

    typedef struct packed {
        logic                 we;
        logic [2*`DATA_W-1:0] data;
    } hiLoWriteT;

    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [wbAdrW-1:0]  adr;
        logic [3:0]         sel;
        logic [`DATA_W-1:0] datW;
    } wbReqT;

    typedef struct packed {
        logic               ack;
        logic [`DATA_W-1:0] datR;
    } wbRspT;

endpackage

// File: logic/memWbTop.sv
`timescale 1ns/1ns

module memWbTop
    import memWbPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      inValid,
    output logic      inReady,
    input  exMemT     inData,
    output rfWriteT   rfWrite,
    output hiLoWriteT hiLoWrite
);

    logic  exValid;
    logic  exReady;
    exMemT exReq;
    logic  memValid;
    logic  memReady;
    memWbT memRes;
    logic  wbValid;
    memWbT wbRes;
    wbReqT wbReq;
    wbRspT wbRsp;

    pipeReg #(.payloadT(exMemT)) inPipe (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inData),
        .outValid (exValid),
        .outReady (exReady),
        .outData  (exReq)
    );

    memAccessStage memAccessStage_inst (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (exValid),
        .inReady  (exReady),
        .req      (exReq),
        .outValid (memValid),
        .outReady (memReady),
        .res      (memRes),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp)
    );

    dataRam dataRam_inst (
        .clk   (clk),
        .rstN  (rstN),
        .wbReq (wbReq),
        .wbRsp (wbRsp)
    );

    // Writeback never stalls, so the result register always drains.
    pipeReg #(.payloadT(memWbT)) resPipe (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (memValid),
        .inReady  (memReady),
        .inData   (memRes),
        .outValid (wbValid),
        .outReady (1'b1),
        .outData  (wbRes)
    );

    writebackStage writebackStage_inst (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (wbValid),
        .res       (wbRes),
        .rfWrite   (rfWrite),
        .hiLoWrite (hiLoWrite)
    );

endmodule

// File: logic/memWb_cfg.svh
`ifndef MEMWB_CFG_SVH
`define MEMWB_CFG_SVH

// Width of the integer data path.
`define DATA_W 32

// Destination address space. 0 to 31 are GPRs, the rest are CP0 slots.
`define DEST_W 7

// Slot that takes the faulting PC.
`define EPC_ADDR 7'd78

// Data RAM depth in 32-bit words.
`define RAM_WORDS 256

`endif

// File: logic/pipeReg.sv
`timescale 1ns/1ns

module pipeReg
#(
    parameter type payloadT = logic
)
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    full;
    payloadT dataQ;

    // Refill in the same cycle the held item drains.
    assign inReady  = !full || outReady;
    assign outValid = full;
    assign outData  = dataQ;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            full <= 1'b0;
        else if (inReady)
            full <= inValid;
    end

    always_ff @(posedge clk)
    begin
        if (inValid && inReady)
            dataQ <= inData;
    end

    holdStable: assert property (
        @(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outData)
    ) else $error("pipeReg: payload changed while stalled");

endmodule

// File: logic/writebackStage.sv
`timescale 1ns/1ns
`include "memWb_cfg.svh"

module writebackStage
    import memWbPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      inValid,
    input  memWbT     res,
    output rfWriteT   rfWrite,
    output hiLoWriteT hiLoWrite
);

    logic [7:0]         laneByte;
    logic [15:0]        laneHalf;
    logic [`DATA_W-1:0] loadVal;
    logic [`DATA_W-1:0] wrData;
    logic [`DEST_W-1:0] wrAddr;

    always_comb
    begin
        case (res.aluResult[1:0])
            2'd0: laneByte = res.memWord[31:24];
            2'd1: laneByte = res.memWord[23:16];
            2'd2: laneByte = res.memWord[15:8];
            default: laneByte = res.memWord[7:0];
        endcase
        laneHalf = res.aluResult[1] ? res.memWord[15:0] : res.memWord[31:16];
    end

    always_comb
    begin
        case (res.size)
            sizeByte: loadVal = {{(`DATA_W-8){res.signExt & laneByte[7]}}, laneByte};
            sizeHalf:
            begin
                if (res.aluResult[0])
                    loadVal = res.memWord; // Misaligned word comes back as is.
                else
                    loadVal = {{(`DATA_W-16){res.signExt & laneHalf[15]}}, laneHalf};
            end
            default: loadVal = res.memWord;
        endcase
    end

    // Exception overrides both the slot and the value.
    assign wrAddr = res.excTaken ? `EPC_ADDR : res.dest;
    assign wrData = res.excTaken ? res.pc : (res.fromMem ? loadVal : res.aluResult);

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            rfWrite.we   <= 1'b0;
            hiLoWrite.we <= 1'b0;
        end
        else
        begin
            rfWrite.we     <= inValid && (res.regWrite || res.excTaken);
            hiLoWrite.we   <= inValid && res.hiLoWe;
            rfWrite.addr   <= wrAddr;
            rfWrite.data   <= wrData;
            hiLoWrite.data <= res.hiLoData;
        end
    end

    halfAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        inValid && res.fromMem && res.size == sizeHalf |-> !res.aluResult[0]
    ) else $warning("writebackStage: misaligned halfword load at %h", res.aluResult);

endmodule

// File: memWbTop.f
+incdir+logic
logic/memWbPkg.sv
logic/pipeReg.sv
logic/memAccessStage.sv
logic/dataRam.sv
logic/writebackStage.sv
logic/memWbTop.sv
verif/memWbChecker.sv
verif/memWbTb.sv

// File: verif/memWbChecker.sv
`timescale 1ns/1ns
`include "memWb_cfg.svh"

module memWbChecker
    import memWbPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      expPush,
    input  rfWriteT   expRf,
    input  hiLoWriteT expHiLo,
    input  rfWriteT   rfWrite,
    input  hiLoWriteT hiLoWrite,
    output int        mismatchCount,
    output int        otherErrCount,
    output int        pendingCount
);

    typedef struct packed {
        rfWriteT   rf;
        hiLoWriteT hiLo;
    } expectT;

    expectT expQ[$]; // One entry per instruction that writes something.
    expectT head;

    task automatic reportMismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] want);
        mismatchCount++;
        $display("Mismatch %s: got %0h, expected %0h at %0t", name, got, want, $time);
    endtask

    task automatic compareWrites(input expectT e);
        if (rfWrite.we !== e.rf.we)
            reportMismatch("rfWrite.we", 64'(rfWrite.we), 64'(e.rf.we));
        if (e.rf.we && rfWrite.addr !== e.rf.addr)
            reportMismatch("rfWrite.addr", 64'(rfWrite.addr), 64'(e.rf.addr));
        if (e.rf.we && rfWrite.data !== e.rf.data)
            reportMismatch("rfWrite.data", 64'(rfWrite.data), 64'(e.rf.data));
        if (hiLoWrite.we !== e.hiLo.we)
            reportMismatch("hiLoWrite.we", 64'(hiLoWrite.we), 64'(e.hiLo.we));
        if (e.hiLo.we && hiLoWrite.data !== e.hiLo.data)
            reportMismatch("hiLoWrite.data", hiLoWrite.data, e.hiLo.data);
    endtask

    // Outputs are registered, so the values seen here are from the last cycle.
    always @(posedge clk)
    begin
        if (!rstN)
            expQ.delete();
        else
        begin
            if (rfWrite.we || hiLoWrite.we)
            begin
                if (expQ.size() == 0)
                begin
                    otherErrCount++;
                    $display("Write output at %0t with no result expected", $time);
                end
                else
                begin
                    head = expQ.pop_front();
                    compareWrites(head);
                end
            end
            if (expPush)
                expQ.push_back({expRf, expHiLo});
        end
        pendingCount = expQ.size();
    end

endmodule

// File: verif/memWbTb.sv
`timescale 1ns/1ns
`include "memWb_cfg.svh"

module memWbTb
    import memWbPkg::*;
();

    localparam int clkPeriod   = 100;
    localparam int resetCycles = 10;
    localparam int aluCount    = 40;
    localparam int pairCount   = 30;
    localparam int laneRounds  = 20;
    localparam int excCount    = 20;
    localparam int burstCount  = 300;
    localparam int numInstr    = `RAM_WORDS + aluCount + 2 * pairCount + 15 * laneRounds
                                 + 2 * excCount + burstCount;
    localparam int timeoutNs   = (numInstr * 8 + resetCycles) * clkPeriod;

    logic               clk = 1'b0;
    logic               rstN;
    logic               inValid;
    logic               inReady;
    exMemT              inData;
    rfWriteT            rfWrite;
    hiLoWriteT          hiLoWrite;
    logic               expPush;
    rfWriteT            expRf;
    hiLoWriteT          expHiLo;
    int                 mismatchCount;
    int                 otherErrCount;
    int                 pendingCount;
    int                 drainErrors = 0;
    logic [31:0]        rngState = 32'd88;
    logic [`DATA_W-1:0] shadowRam [`RAM_WORDS];

    always #(clkPeriod / 2) clk = ~clk;

    memWbTop memWbTop_inst (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inReady   (inReady),
        .inData    (inData),
        .rfWrite   (rfWrite),
        .hiLoWrite (hiLoWrite)
    );

    memWbChecker resultCheck (
        .clk           (clk),
        .rstN          (rstN),
        .expPush       (expPush),
        .expRf         (expRf),
        .expHiLo       (expHiLo),
        .rfWrite       (rfWrite),
        .hiLoWrite     (hiLoWrite),
        .mismatchCount (mismatchCount),
        .otherErrCount (otherErrCount),
        .pendingCount  (pendingCount)
    );

    function automatic logic [31:0] xorshift32();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Expected writes of one instruction. Stores update the shadow RAM.
    function automatic void refModel(input exMemT x, output rfWriteT rf, output hiLoWriteT hl);
        int                 idx;
        int                 hi;
        logic [`DATA_W-1:0] word;
        logic [`DATA_W-1:0] loadVal;
        idx  = int'(x.aluResult >> 2) % `RAM_WORDS;
        word = shadowRam[idx];
        case (x.memOp.size) // Top bit of the addressed lane in big-endian order.
            sizeByte: hi = 31 - 8 * int'(x.aluResult[1:0]);
            sizeHalf: hi = 31 - 16 * int'(x.aluResult[1]);
            default:  hi = 31;
        endcase
        if (x.memOp.write)
        begin
            case (x.memOp.size)
                sizeByte: word[hi -: 8]  = x.storeData[7:0];
                sizeHalf: word[hi -: 16] = x.storeData[15:0];
                default:  word           = x.storeData;
            endcase
            shadowRam[idx] = word;
        end
        case (x.memOp.size)
            sizeByte: loadVal = {{24{x.memOp.signExt & word[hi]}}, word[hi -: 8]};
            sizeHalf: loadVal = {{16{x.memOp.signExt & word[hi]}}, word[hi -: 16]};
            default:  loadVal = word;
        endcase
        rf.we   = x.regWrite || x.excTaken;
        rf.addr = x.excTaken ? `EPC_ADDR : x.dest;
        rf.data = x.excTaken ? x.pc : (x.memOp.read ? loadVal : x.aluResult);
        hl.we   = x.hiLoWe;
        hl.data = x.hiLoData;
    endfunction

    function automatic exMemT randomAlu();
        exMemT x;
        x           = '0;
        x.aluResult = xorshift32();
        x.storeData = xorshift32();
        x.dest      = 7'(xorshift32() & 32'h1f);
        x.regWrite  = (xorshift32() & 32'h7) != 0; // Mostly writing.
        x.pc        = xorshift32() & 32'hfffffffc;
        x.hiLoWe    = (xorshift32() & 32'h1) != 0;
        x.hiLoData  = {xorshift32(), xorshift32()};
        return x;
    endfunction

    function automatic exMemT randomExc();
        exMemT x;
        x          = randomAlu();
        x.excTaken = 1'b1;
        x.dest     = 7'(xorshift32());
        return x;
    endfunction

    function automatic exMemT memInstr(input logic wr, input accSizeT size, input int idx,
                                       input int off, input logic sx);
        exMemT x;
        x               = randomAlu();
        x.aluResult     = 32'(idx * 4 + off);
        x.memOp.read    = !wr;
        x.memOp.write   = wr;
        x.memOp.size    = size;
        x.memOp.signExt = sx;
        x.regWrite      = !wr;
        x.hiLoWe        = 1'b0;
        return x;
    endfunction

    function automatic exMemT randomMem(input logic wr);
        accSizeT size;
        int      off;
        size = accSizeT'(2'(xorshift32() % 3));
        off  = int'(xorshift32() % 4);
        if (size == sizeHalf)
            off = off & 2;
        if (size == sizeWord)
            off = 0;
        return memInstr(wr, size, int'(xorshift32() % `RAM_WORDS), off,
                        (xorshift32() & 32'h1) != 0);
    endfunction

    // Called on a falling edge. Returns on the falling edge after acceptance.
    task automatic sendInstr(input exMemT x);
        rfWriteT   rfExp;
        hiLoWriteT hlExp;
        refModel(x, rfExp, hlExp);
        inData  = x;
        inValid = 1'b1;
        while (!inReady)
            @(negedge clk);
        expRf   = rfExp;
        expHiLo = hlExp;
        expPush = rfExp.we || hlExp.we;
        @(negedge clk);
        expPush = 1'b0;
    endtask

    task automatic idle(input int cycles);
        inValid = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    initial
    begin
        #(timeoutNs);
        $display("Timeout after %0d ns, results stopped arriving", timeoutNs);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        exMemT x;
        int    idx;
        rstN    = 1'b0;
        inValid = 1'b0;
        inData  = '0;
        expPush = 1'b0;
        expRf   = '0;
        expHiLo = '0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        // Every word gets a known value before any load.
        for (int i = 0; i < `RAM_WORDS; i++)
        begin
            x           = memInstr(1'b1, sizeWord, i, 0, 1'b0);
            x.storeData = (32'(i) * 32'h9e3779b1) ^ {24'h5a5a5a, 8'(i)};
            sendInstr(x);
        end

        for (int i = 0; i < aluCount; i++)
        begin
            sendInstr(randomAlu());
            idle(int'(xorshift32() % 3));
        end

        for (int i = 0; i < pairCount; i++)
        begin
            idx = int'(xorshift32() % `RAM_WORDS);
            sendInstr(memInstr(1'b1, sizeWord, idx, 0, 1'b0));
            idle(int'(xorshift32() % 3));
            sendInstr(memInstr(1'b0, sizeWord, idx, 0, 1'b0));
        end

        for (int i = 0; i < laneRounds; i++)
        begin
            idx = int'(xorshift32() % `RAM_WORDS);
            sendInstr(memInstr(1'b1, sizeByte, idx, int'(xorshift32() % 4), 1'b0));
            sendInstr(memInstr(1'b1, sizeHalf, idx, 2 * int'(xorshift32() % 2), 1'b0));
            for (int s = 0; s < 2; s++)
            begin
                for (int b = 0; b < 4; b++)
                    sendInstr(memInstr(1'b0, sizeByte, idx, b, s[0]));
                for (int h = 0; h < 2; h++)
                    sendInstr(memInstr(1'b0, sizeHalf, idx, 2 * h, s[0]));
            end
            sendInstr(memInstr(1'b0, sizeWord, idx, 0, 1'b0)); // Untouched lanes.
        end

        for (int i = 0; i < excCount; i++)
        begin
            sendInstr(randomExc());
            sendInstr(randomAlu());
        end

        // inValid stays high through the whole burst.
        for (int i = 0; i < burstCount; i++)
        begin
            case (int'(xorshift32() % 4))
                0: sendInstr(randomAlu());
                1: sendInstr(randomMem(1'b1));
                2: sendInstr(randomMem(1'b0));
                default: sendInstr(randomExc());
            endcase
        end

        inValid = 1'b0;
        for (int i = 0; i < 50 && pendingCount != 0; i++)
            @(negedge clk);
        repeat (10) @(negedge clk);
        if (pendingCount != 0)
        begin
            drainErrors = pendingCount;
            $display("%0d expected results never appeared at the outputs", pendingCount);
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount,
                 otherErrCount + drainErrors);
        if (mismatchCount + otherErrCount + drainErrors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule
